// File: verilog/cpuControlPkg.sv
// CPU control definitions
`default_nettype none

package cpuControlPkg;

   typedef enum logic [4:0] {
      ADD    = 5'd0,
      ADDI   = 5'd1,
      ADDIB  = 5'd2,   // rd is also the source
      ADC    = 5'd3,
      ADCI   = 5'd4,
      SUB    = 5'd5,
      SUBI   = 5'd6,
      SUBIB  = 5'd7,
      SUC    = 5'd8,
      SUCI   = 5'd9,
      CMP    = 5'd10,
      CMPI   = 5'd11,
      AND    = 5'd12,
      OR     = 5'd13,
      XOR    = 5'd14,
      NOT    = 5'd15,
      NAND   = 5'd16,
      NOR    = 5'd17,
      NEG    = 5'd18,
      LSL    = 5'd19,
      LSR    = 5'd20,
      ASR    = 5'd21,
      LUI    = 5'd22,
      LLI    = 5'd23,
      LDW    = 5'd24,
      STW    = 5'd25,
      BRANCH = 5'd26   // low three bits select the branch
   } opcode_t;

   typedef enum logic [2:0] {
      BR  = 3'd0,
      BNE = 3'd1,
      BE  = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4,
      BWL = 3'd5,   // branch with link
      RET = 3'd6,
      JMP = 3'd7
   } branch_t;

   typedef enum logic [3:0] {
      FnA, FnADD, FnADC, FnSUB, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR, FnLUI, FnLLI
   } aluFn_t;

   typedef enum logic       {Op1Rd1 = 1'b0, Op1Pc = 1'b1} op1Sel_t;
   typedef enum logic [1:0] {Op2Imm = 2'd0, Op2Rd2 = 2'd1} op2Sel_t;
   typedef enum logic       {ImmShort = 1'b0, ImmLong = 1'b1} immSel_t;
   typedef enum logic [1:0] {WdAlu = 2'd0, WdSys = 2'd1} wdSel_t;
   typedef enum logic       {Rs1Ra = 1'b0, Rs1Rd = 1'b1} rs1Sel_t;
   typedef enum logic [1:0] {Pc1 = 2'd0, PcAluOut = 2'd1, PcSysbus = 2'd2} pcSel_t;
   typedef enum logic       {LrSys = 1'b0, LrPc = 1'b1} lrSel_t;

   typedef enum logic [1:0] {Fetch = 2'd0, Execute = 2'd1} majorState_t;
   typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} subCycle_t;

   localparam int FlagWidth = 4;
   localparam int FlagC     = 0;
   localparam int FlagZ     = 1;
   localparam int FlagN     = 2;
   localparam int FlagV     = 3;

   typedef struct packed {
      aluFn_t  aluOp;
      op1Sel_t op1Sel;
      op2Sel_t op2Sel;
      immSel_t immSel;
      rs1Sel_t rs1Sel;
      wdSel_t  wdSel;
      logic    aluEn;   // alu result onto sysbus
      logic    aluWe;   // alu output register load
      logic    regWe;
   } datapathCtrl_t;

   typedef struct packed {
      logic    pcWe;
      logic    pcEn;    // pc onto sysbus
      pcSel_t  pcSel;
      logic    irWe;
      logic    lrEn;
      logic    lrWe;
      lrSel_t  lrSel;
   } pcCtrl_t;

   typedef struct packed {
      logic    memEn;   // pad direction toward core
      logic    nWE;
      logic    nOE;
      logic    nME;
      logic    enb;
      logic    ale;
   } busCtrl_t;

endpackage

`default_nettype wire

// File: verilog/sequencer.sv
// Fetch and execute sequencer
`timescale 1ns/1ps
`default_nettype none

module sequencer (
   input  logic                       Clock,
   input  logic                       nReset,
   input  cpuControlPkg::opcode_t     Opcode,
   output cpuControlPkg::majorState_t State,
   output cpuControlPkg::subCycle_t   SubCycle
);

   logic                       IsMemory;
   cpuControlPkg::majorState_t StateNext;
   cpuControlPkg::subCycle_t   SubCycleNext;
   cpuControlPkg::subCycle_t   SubCycleInc;

   assign IsMemory    = (Opcode == cpuControlPkg::LDW) || (Opcode == cpuControlPkg::STW);
   assign SubCycleInc = cpuControlPkg::subCycle_t'(SubCycle + 3'd1);

   always_comb begin
      StateNext    = cpuControlPkg::Fetch;   // recovery point for unused codes
      SubCycleNext = cpuControlPkg::Cycle0;
      case (State)
         cpuControlPkg::Fetch: begin
            case (SubCycle)
               cpuControlPkg::Cycle0, cpuControlPkg::Cycle1, cpuControlPkg::Cycle2: begin
                  SubCycleNext = SubCycleInc;
               end
               default: begin
                  StateNext = cpuControlPkg::Execute;   // instruction now in IR
               end
            endcase
         end
         cpuControlPkg::Execute: begin
            case (SubCycle)
               cpuControlPkg::Cycle0: begin
                  if (IsMemory) begin
                     StateNext    = cpuControlPkg::Execute;
                     SubCycleNext = cpuControlPkg::Cycle1;
                  end
               end
               cpuControlPkg::Cycle1, cpuControlPkg::Cycle2, cpuControlPkg::Cycle3: begin
                  StateNext    = cpuControlPkg::Execute;
                  SubCycleNext = SubCycleInc;
               end
               default: ;   // cycle4 ends the memory access
            endcase
         end
         default: ;
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         State    <= cpuControlPkg::Fetch;
         SubCycle <= cpuControlPkg::Cycle0;
      end else begin
         State    <= StateNext;
         SubCycle <= SubCycleNext;
      end
   end

endmodule

`default_nettype wire

// File: verilog/branchCondition.sv
// Status register and branch condition
`timescale 1ns/1ps
`default_nettype none

module branchCondition (
   input  logic                                Clock,
   input  logic                                nReset,
   input  logic [cpuControlPkg::FlagWidth-1:0] Flags,
   input  logic                                StatusWe,
   input  cpuControlPkg::branch_t              BranchCode,
   output logic                                BranchTaken,
   output logic                                CFlag
);

   logic [cpuControlPkg::FlagWidth-1:0] StatusReg;
   logic                                SignLess;

   // signed less-than after a compare
   assign SignLess = StatusReg[cpuControlPkg::FlagN] ^ StatusReg[cpuControlPkg::FlagV];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         StatusReg <= '0;
         CFlag     <= 1'b0;
      end else begin
         if (StatusWe) begin
            StatusReg <= Flags;   // latched from the alu
         end
         CFlag <= StatusReg[cpuControlPkg::FlagC];   // carry into the next add
      end
   end

   always_comb begin
      case (BranchCode)
         cpuControlPkg::BNE: BranchTaken = !StatusReg[cpuControlPkg::FlagZ];
         cpuControlPkg::BE:  BranchTaken = StatusReg[cpuControlPkg::FlagZ];
         cpuControlPkg::BLT: BranchTaken = SignLess;
         cpuControlPkg::BGE: BranchTaken = !SignLess;
         default:            BranchTaken = 1'b1;   // br, bwl, ret and jmp
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/controlDecoder.sv
// Control strobe decoder
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
   input  cpuControlPkg::majorState_t   State,
   input  cpuControlPkg::subCycle_t     SubCycle,
   input  cpuControlPkg::opcode_t       Opcode,
   input  cpuControlPkg::branch_t       BranchCode,
   input  logic                         BranchTaken,
   output logic                         StatusWe,
   output cpuControlPkg::datapathCtrl_t Datapath,
   output cpuControlPkg::pcCtrl_t       ProgCounter,
   output cpuControlPkg::busCtrl_t      MemBus
);

   logic IsLoad;

   assign IsLoad = (Opcode == cpuControlPkg::LDW);

   function automatic cpuControlPkg::aluFn_t aluFunction(input cpuControlPkg::opcode_t op);
      case (op)
         cpuControlPkg::ADD, cpuControlPkg::ADDI, cpuControlPkg::ADDIB,
         cpuControlPkg::LDW, cpuControlPkg::STW:  aluFunction = cpuControlPkg::FnADD;
         cpuControlPkg::ADC, cpuControlPkg::ADCI,
         cpuControlPkg::SUC, cpuControlPkg::SUCI: aluFunction = cpuControlPkg::FnADC;
         cpuControlPkg::SUB, cpuControlPkg::SUBI, cpuControlPkg::SUBIB,
         cpuControlPkg::CMP, cpuControlPkg::CMPI: aluFunction = cpuControlPkg::FnSUB;
         cpuControlPkg::NEG:  aluFunction = cpuControlPkg::FnNEG;
         cpuControlPkg::AND:  aluFunction = cpuControlPkg::FnAND;
         cpuControlPkg::OR:   aluFunction = cpuControlPkg::FnOR;
         cpuControlPkg::XOR:  aluFunction = cpuControlPkg::FnXOR;
         cpuControlPkg::NOT:  aluFunction = cpuControlPkg::FnNOT;
         cpuControlPkg::NAND: aluFunction = cpuControlPkg::FnNAND;
         cpuControlPkg::NOR:  aluFunction = cpuControlPkg::FnNOR;
         cpuControlPkg::LSL:  aluFunction = cpuControlPkg::FnLSL;
         cpuControlPkg::LSR:  aluFunction = cpuControlPkg::FnLSR;
         cpuControlPkg::ASR:  aluFunction = cpuControlPkg::FnASR;
         cpuControlPkg::LUI:  aluFunction = cpuControlPkg::FnLUI;
         cpuControlPkg::LLI:  aluFunction = cpuControlPkg::FnLLI;
         default:             aluFunction = cpuControlPkg::FnA;   // pass op1 through
      endcase
   endfunction

   always_comb begin
      StatusWe    = 1'b0;
      Datapath    = '{aluOp: cpuControlPkg::FnA, op1Sel: cpuControlPkg::Op1Rd1,
                      op2Sel: cpuControlPkg::Op2Imm, immSel: cpuControlPkg::ImmLong,
                      rs1Sel: cpuControlPkg::Rs1Ra, wdSel: cpuControlPkg::WdAlu,
                      default: 1'b0};
      ProgCounter = '{pcSel: cpuControlPkg::Pc1, lrSel: cpuControlPkg::LrSys, default: 1'b0};
      MemBus      = '{nME: 1'b1, default: 1'b0};   // memory deselected

      if (State == cpuControlPkg::Fetch) begin
         MemBus.nWE = 1'b1;   // fetch only reads
         case (SubCycle)
            cpuControlPkg::Cycle0: begin
               MemBus.ale       = 1'b1;   // pc latched as address
               MemBus.nOE       = 1'b1;
               ProgCounter.pcEn = 1'b1;
            end
            cpuControlPkg::Cycle1: begin
               MemBus.nME   = 1'b0;
               MemBus.memEn = 1'b1;
            end
            cpuControlPkg::Cycle2: begin
               MemBus.nME   = 1'b0;
               MemBus.memEn = 1'b1;
               MemBus.enb   = 1'b1;   // instruction onto sysbus
            end
            cpuControlPkg::Cycle3: begin
               MemBus.memEn     = 1'b1;
               ProgCounter.irWe = 1'b1;
            end
            default: ;
         endcase
      end else if (State == cpuControlPkg::Execute) begin
         case (SubCycle)
            cpuControlPkg::Cycle0: begin
               Datapath.aluOp = aluFunction(Opcode);
               case (Opcode)
                  cpuControlPkg::ADD, cpuControlPkg::ADDI, cpuControlPkg::ADDIB,
                  cpuControlPkg::ADC, cpuControlPkg::ADCI, cpuControlPkg::SUB,
                  cpuControlPkg::SUBI, cpuControlPkg::SUBIB, cpuControlPkg::SUC,
                  cpuControlPkg::SUCI, cpuControlPkg::CMP, cpuControlPkg::CMPI,
                  cpuControlPkg::AND, cpuControlPkg::OR, cpuControlPkg::XOR,
                  cpuControlPkg::NOT, cpuControlPkg::NAND, cpuControlPkg::NOR,
                  cpuControlPkg::NEG, cpuControlPkg::LSL, cpuControlPkg::LSR,
                  cpuControlPkg::ASR: begin
                     Datapath.regWe = (Opcode != cpuControlPkg::CMP) &&
                                      (Opcode != cpuControlPkg::CMPI);   // compare sets flags only
                     ProgCounter.pcEn = 1'b1;
                     ProgCounter.pcWe = 1'b1;
                     StatusWe         = 1'b1;
                     case (Opcode)
                        cpuControlPkg::ADD, cpuControlPkg::ADC, cpuControlPkg::SUB,
                        cpuControlPkg::SUC, cpuControlPkg::CMP, cpuControlPkg::AND,
                        cpuControlPkg::OR, cpuControlPkg::XOR, cpuControlPkg::NAND,
                        cpuControlPkg::NOR: Datapath.op2Sel = cpuControlPkg::Op2Rd2;
                        cpuControlPkg::ADDIB, cpuControlPkg::SUBIB: begin
                           Datapath.rs1Sel = cpuControlPkg::Rs1Rd;   // rd is the source
                        end
                        cpuControlPkg::NOT, cpuControlPkg::NEG: ;   // single operand
                        default: Datapath.immSel = cpuControlPkg::ImmShort;
                     endcase
                  end
                  cpuControlPkg::LUI, cpuControlPkg::LLI: begin
                     Datapath.rs1Sel  = cpuControlPkg::Rs1Rd;
                     Datapath.aluEn   = 1'b1;
                     Datapath.regWe   = 1'b1;
                     ProgCounter.pcWe = 1'b1;
                  end
                  cpuControlPkg::LDW, cpuControlPkg::STW: begin
                     Datapath.immSel = cpuControlPkg::ImmShort;   // base plus offset
                     Datapath.aluEn  = 1'b1;
                     Datapath.aluWe  = 1'b1;
                  end
                  cpuControlPkg::BRANCH: begin
                     ProgCounter.pcWe = 1'b1;
                     case (BranchCode)
                        cpuControlPkg::RET: begin
                           Datapath.aluOp    = cpuControlPkg::FnA;
                           ProgCounter.lrEn  = 1'b1;   // return address via sysbus
                           ProgCounter.pcSel = cpuControlPkg::PcSysbus;
                        end
                        cpuControlPkg::JMP: begin
                           Datapath.aluOp  = cpuControlPkg::FnADD;
                           Datapath.immSel = cpuControlPkg::ImmShort;
                           if (BranchTaken) begin
                              ProgCounter.pcSel = cpuControlPkg::PcAluOut;
                           end
                        end
                        default: begin
                           Datapath.aluOp  = cpuControlPkg::FnADD;   // pc relative target
                           Datapath.op1Sel = cpuControlPkg::Op1Pc;
                           Datapath.aluEn  = 1'b1;
                           if (BranchTaken) begin
                              ProgCounter.pcSel = cpuControlPkg::PcAluOut;
                              if (BranchCode == cpuControlPkg::BWL) begin
                                 ProgCounter.lrWe  = 1'b1;
                                 ProgCounter.lrSel = cpuControlPkg::LrPc;
                              end
                           end
                        end
                     endcase
                  end
                  default: ;
               endcase
            end
            cpuControlPkg::Cycle1: begin
               MemBus.ale      = 1'b1;   // effective address out
               MemBus.nWE      = 1'b1;
               MemBus.nOE      = 1'b1;
               Datapath.aluOp  = cpuControlPkg::FnADD;
               Datapath.immSel = cpuControlPkg::ImmShort;
               Datapath.aluEn  = 1'b1;
            end
            cpuControlPkg::Cycle2: begin
               MemBus.nME      = 1'b0;
               MemBus.nWE      = 1'b1;
               MemBus.memEn    = IsLoad;
               MemBus.nOE      = !IsLoad;
               Datapath.rs1Sel = cpuControlPkg::Rs1Rd;   // store data passes the alu
               Datapath.aluEn  = 1'b1;
               Datapath.aluWe  = 1'b1;
            end
            cpuControlPkg::Cycle3: begin
               MemBus.nME = 1'b0;
               if (IsLoad) begin
                  MemBus.memEn = 1'b1;
                  MemBus.enb   = 1'b1;
                  MemBus.nWE   = 1'b1;
               end else begin
                  MemBus.nOE     = 1'b1;   // write strobe while data held
                  Datapath.aluEn = 1'b1;
               end
            end
            cpuControlPkg::Cycle4: begin
               ProgCounter.pcWe = 1'b1;
               if (IsLoad) begin
                  MemBus.nWE     = 1'b1;
                  MemBus.memEn   = 1'b1;
                  Datapath.wdSel = cpuControlPkg::WdSys;
                  Datapath.regWe = 1'b1;
               end else begin
                  MemBus.nOE     = 1'b1;
                  Datapath.aluEn = 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/controlUnit.sv
// Instruction control unit
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
   input  logic                                Clock,
   input  logic                                nReset,
   input  logic [7:0]                          OpcodeCondIn,
   input  logic [cpuControlPkg::FlagWidth-1:0] Flags,
   output cpuControlPkg::datapathCtrl_t        Datapath,
   output cpuControlPkg::pcCtrl_t              ProgCounter,
   output cpuControlPkg::busCtrl_t             MemBus,
   output logic                                CFlag
);

   cpuControlPkg::opcode_t     Opcode;
   cpuControlPkg::branch_t     BranchCode;
   cpuControlPkg::majorState_t State;
   cpuControlPkg::subCycle_t   SubCycle;
   logic                       BranchTaken;
   logic                       StatusWe;

   assign Opcode     = cpuControlPkg::opcode_t'(OpcodeCondIn[7:3]);
   assign BranchCode = cpuControlPkg::branch_t'(OpcodeCondIn[2:0]);   // condition field

   sequencer sequencer_i (
      .Clock    (Clock),
      .nReset   (nReset),
      .Opcode   (Opcode),
      .State    (State),
      .SubCycle (SubCycle)
   );

   branchCondition branchCondition_i (
      .Clock       (Clock),
      .nReset      (nReset),
      .Flags       (Flags),
      .StatusWe    (StatusWe),
      .BranchCode  (BranchCode),
      .BranchTaken (BranchTaken),
      .CFlag       (CFlag)
   );

   controlDecoder controlDecoder_i (
      .State       (State),
      .SubCycle    (SubCycle),
      .Opcode      (Opcode),
      .BranchCode  (BranchCode),
      .BranchTaken (BranchTaken),
      .StatusWe    (StatusWe),
      .Datapath    (Datapath),
      .ProgCounter (ProgCounter),
      .MemBus      (MemBus)
   );

endmodule

`default_nettype wire

// File: test/clockGen.sv
// Clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module clockGen (
   output logic Clock,
   output logic nReset
);

   initial begin
      Clock = 1'b0;
      forever #2 Clock = ~Clock;   // 4 ns period
   end

   initial begin
      nReset = 1'b0;
      repeat (10) @(posedge Clock);
      @(negedge Clock);
      nReset = 1'b1;   // released away from the active edge
   end

endmodule

`default_nettype wire

// File: test/controlUnitAssertions.sv
// Control unit timing checks
`timescale 1ns/1ps
`default_nettype none

module controlUnitAssertions (
   input logic                                Clock,
   input logic                                nReset,
   input logic [7:0]                          OpcodeCondIn,
   input logic [cpuControlPkg::FlagWidth-1:0] Flags,
   input cpuControlPkg::datapathCtrl_t        Datapath,
   input cpuControlPkg::pcCtrl_t              ProgCounter,
   input cpuControlPkg::busCtrl_t             MemBus,
   input logic                                CFlag
);

   int                                  failCount = 0;
   cpuControlPkg::opcode_t              opcode;
   cpuControlPkg::branch_t              branchCode;
   cpuControlPkg::aluFn_t               aluExpected;
   cpuControlPkg::pcSel_t               pcExpected;
   logic [cpuControlPkg::FlagWidth-1:0] statusModel;
   logic [3:0]                          sinceAle;   // cycles since the last fetch ALE
   logic                                seenFetch;
   logic                                instrIsMem;
   logic                                fetchStart;
   logic                                execStart;
   logic                                aluInstr;
   logic                                isCompare;
   logic                                isLoad;
   logic                                isStore;
   logic                                aluKnown;
   logic                                taken;

   assign opcode     = cpuControlPkg::opcode_t'(OpcodeCondIn[7:3]);
   assign branchCode = cpuControlPkg::branch_t'(OpcodeCondIn[2:0]);
   assign fetchStart = MemBus.ale && ProgCounter.pcEn;
   assign execStart  = seenFetch && (sinceAle == 4'd4);
   assign aluInstr   = opcode <= cpuControlPkg::ASR;   // arithmetic, logic and shifts
   assign isCompare  = (opcode == cpuControlPkg::CMP) || (opcode == cpuControlPkg::CMPI);
   assign isLoad     = opcode == cpuControlPkg::LDW;
   assign isStore    = opcode == cpuControlPkg::STW;

   always_comb begin
      aluKnown    = 1'b1;
      aluExpected = cpuControlPkg::FnA;
      case (opcode)
         cpuControlPkg::ADD, cpuControlPkg::ADDI,
         cpuControlPkg::ADDIB: aluExpected = cpuControlPkg::FnADD;
         cpuControlPkg::ADC, cpuControlPkg::ADCI: aluExpected = cpuControlPkg::FnADC;
         cpuControlPkg::SUB, cpuControlPkg::SUBI, cpuControlPkg::SUBIB,
         cpuControlPkg::CMP, cpuControlPkg::CMPI: aluExpected = cpuControlPkg::FnSUB;
         cpuControlPkg::AND:  aluExpected = cpuControlPkg::FnAND;
         cpuControlPkg::OR:   aluExpected = cpuControlPkg::FnOR;
         cpuControlPkg::XOR:  aluExpected = cpuControlPkg::FnXOR;
         cpuControlPkg::NOT:  aluExpected = cpuControlPkg::FnNOT;
         cpuControlPkg::NAND: aluExpected = cpuControlPkg::FnNAND;
         cpuControlPkg::NOR:  aluExpected = cpuControlPkg::FnNOR;
         cpuControlPkg::NEG:  aluExpected = cpuControlPkg::FnNEG;
         cpuControlPkg::LSL:  aluExpected = cpuControlPkg::FnLSL;
         cpuControlPkg::LSR:  aluExpected = cpuControlPkg::FnLSR;
         cpuControlPkg::ASR:  aluExpected = cpuControlPkg::FnASR;
         cpuControlPkg::LUI:  aluExpected = cpuControlPkg::FnLUI;
         cpuControlPkg::LLI:  aluExpected = cpuControlPkg::FnLLI;
         default:             aluKnown    = 1'b0;   // carry subtract and memory not checked
      endcase
   end

   always_comb begin
      case (branchCode)
         cpuControlPkg::BE:  taken = statusModel[cpuControlPkg::FlagZ];
         cpuControlPkg::BNE: taken = !statusModel[cpuControlPkg::FlagZ];
         cpuControlPkg::BLT: taken = statusModel[cpuControlPkg::FlagN] !=
                                     statusModel[cpuControlPkg::FlagV];
         cpuControlPkg::BGE: taken = statusModel[cpuControlPkg::FlagN] ==
                                     statusModel[cpuControlPkg::FlagV];
         default:            taken = 1'b1;
      endcase
      if (branchCode == cpuControlPkg::RET) begin
         pcExpected = cpuControlPkg::PcSysbus;
      end else begin
         pcExpected = taken ? cpuControlPkg::PcAluOut : cpuControlPkg::Pc1;
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         seenFetch   <= 1'b0;
         sinceAle    <= 4'd0;
         instrIsMem  <= 1'b0;
         statusModel <= '0;
      end else begin
         if (fetchStart) begin
            seenFetch <= 1'b1;
            sinceAle  <= 4'd1;
         end else if (sinceAle != 4'hf) begin
            sinceAle <= sinceAle + 4'd1;   // saturates on a stuck sequencer
         end
         if (execStart) begin
            instrIsMem <= isLoad || isStore;
         end
         if (execStart && aluInstr) begin
            statusModel <= Flags;
         end
      end
   end

   resetIdle: assert property (@(posedge Clock)
      !nReset |-> fetchStart && MemBus.nME && !ProgCounter.pcWe && !Datapath.regWe && !CFlag)
      else begin
         failCount++;
         $error("outputs not idle in fetch Cycle0 during reset");
      end

   fetchSelect: assert property (@(posedge Clock) disable iff (!nReset)
      sinceAle == 4'd1 |-> !MemBus.nME && !MemBus.enb)
      else begin
         failCount++;
         $error("fetch Cycle1 does not select memory alone");
      end

   fetchEnable: assert property (@(posedge Clock) disable iff (!nReset)
      sinceAle == 4'd2 |-> !MemBus.nME && MemBus.enb)
      else begin
         failCount++;
         $error("fetch Cycle2 lacks nME low with ENB");
      end

   fetchLoadIr: assert property (@(posedge Clock) disable iff (!nReset)
      sinceAle == 4'd3 |-> ProgCounter.irWe && MemBus.nME)
      else begin
         failCount++;
         $error("fetch Cycle3 does not load the IR");
      end

   aluRegWrite: assert property (@(posedge Clock) disable iff (!nReset)
      execStart && aluInstr |-> Datapath.regWe == !isCompare)
      else begin
         failCount++;
         $error("[ERROR] regWe expected %h got %h", !isCompare, Datapath.regWe);
      end

   aluPcStep: assert property (@(posedge Clock) disable iff (!nReset)
      execStart && aluInstr |-> ProgCounter.pcWe && ProgCounter.pcSel == cpuControlPkg::Pc1)
      else begin
         failCount++;
         $error("ALU opcode does not step the PC by one");
      end

   aluFunction: assert property (@(posedge Clock) disable iff (!nReset)
      execStart && aluKnown |-> Datapath.aluOp == aluExpected)
      else begin
         failCount++;
         $error("[ERROR] aluOp expected %h got %h", aluExpected, Datapath.aluOp);
      end

   singleCycle: assert property (@(posedge Clock) disable iff (!nReset)
      execStart && !(isLoad || isStore) |=> fetchStart)
      else begin
         failCount++;
         $error("fetch ALE missing one cycle after execute");
      end

   aleInterval: assert property (@(posedge Clock) disable iff (!nReset)
      fetchStart && seenFetch |-> sinceAle == (instrIsMem ? 4'd9 : 4'd5))
      else begin
         failCount++;
         $error("[ERROR] ALE interval expected %h got %h", instrIsMem ? 4'd9 : 4'd5, sinceAle);
      end

   carryOut: assert property (@(posedge Clock) disable iff (!nReset)
      $past(execStart && aluInstr, 2) |-> CFlag == $past(Flags[cpuControlPkg::FlagC], 2))
      else begin
         failCount++;
         $error("[ERROR] CFlag expected %h got %h", $past(Flags[cpuControlPkg::FlagC], 2), CFlag);
      end

   branchTarget: assert property (@(posedge Clock) disable iff (!nReset)
      execStart && opcode == cpuControlPkg::BRANCH |->
         ProgCounter.pcWe && ProgCounter.pcSel == pcExpected)
      else begin
         failCount++;
         $error("[ERROR] pcSel expected %h got %h", pcExpected, ProgCounter.pcSel);
      end

   branchLink: assert property (@(posedge Clock) disable iff (!nReset)
      execStart && opcode == cpuControlPkg::BRANCH |->
         ProgCounter.lrWe == (branchCode == cpuControlPkg::BWL) &&
         (branchCode != cpuControlPkg::BWL || ProgCounter.lrSel == cpuControlPkg::LrPc))
      else begin
         failCount++;
         $error("[ERROR] lrWe expected %h got %h", branchCode == cpuControlPkg::BWL,
                ProgCounter.lrWe);
      end

   returnLink: assert property (@(posedge Clock) disable iff (!nReset)
      execStart && opcode == cpuControlPkg::BRANCH && branchCode == cpuControlPkg::RET |->
         ProgCounter.lrEn)
      else begin
         failCount++;
         $error("RET does not put the link register on the bus");
      end

   loadWriteBack: assert property (@(posedge Clock) disable iff (!nReset)
      sinceAle == 4'd8 && isLoad |-> Datapath.wdSel == cpuControlPkg::WdSys && Datapath.regWe)
      else begin
         failCount++;
         $error("LDW does not write sysbus data in execute Cycle4");
      end

   storeNoWrite: assert property (@(posedge Clock) disable iff (!nReset)
      sinceAle >= 4'd4 && sinceAle <= 4'd8 && isStore |-> !Datapath.regWe)
      else begin
         failCount++;
         $error("[ERROR] regWe expected 0 got %h", Datapath.regWe);
      end

   storeOutput: assert property (@(posedge Clock) disable iff (!nReset)
      sinceAle == 4'd7 && isStore |-> MemBus.nOE)
      else begin
         failCount++;
         $error("[ERROR] nOE expected 1 got %h", MemBus.nOE);
      end

endmodule

bind controlUnit controlUnitAssertions controlUnitAssertions_i (
   .Clock        (Clock),
   .nReset       (nReset),
   .OpcodeCondIn (OpcodeCondIn),
   .Flags        (Flags),
   .Datapath     (Datapath),
   .ProgCounter  (ProgCounter),
   .MemBus       (MemBus),
   .CFlag        (CFlag)
);

`default_nettype wire

// File: test/controlUnitTb.sv
// Control unit testbench
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

   localparam int FetchTimeout = 20;   // longest instruction takes 9 cycles
   localparam int ResetTimeout = 40;

   logic                                Clock;
   logic                                nReset;
   logic [7:0]                          OpcodeCondIn;
   logic [cpuControlPkg::FlagWidth-1:0] Flags;
   cpuControlPkg::datapathCtrl_t        Datapath;
   cpuControlPkg::pcCtrl_t              ProgCounter;
   cpuControlPkg::busCtrl_t             MemBus;
   logic                                CFlag;
   logic                                fetchStart;
   logic [31:0]                         lcgState;
   int                                  timeouts;
   int                                  failures;

   assign fetchStart = MemBus.ale && MemBus.nWE && ProgCounter.pcEn;   // fetch Cycle0

   clockGen clockGen_i (
      .Clock  (Clock),
      .nReset (nReset)
   );

   controlUnit controlUnit_i (
      .Clock        (Clock),
      .nReset       (nReset),
      .OpcodeCondIn (OpcodeCondIn),
      .Flags        (Flags),
      .Datapath     (Datapath),
      .ProgCounter  (ProgCounter),
      .MemBus       (MemBus),
      .CFlag        (CFlag)
   );

   function automatic logic [31:0] lcgNext(input logic [31:0] seed);
      return seed * 32'd1664525 + 32'd1013904223;
   endfunction

   // waits for the next fetch Cycle0 and holds the instruction until the one after
   task automatic runInstruction(input logic [4:0] opcode, input logic [2:0] code);
      int waited;
      waited = 0;
      @(negedge Clock);
      while (!fetchStart && waited < FetchTimeout) begin
         @(negedge Clock);
         waited++;
      end
      if (!fetchStart) begin
         timeouts++;
         $display("timeout: no fetch ALE within %0d cycles", FetchTimeout);
      end
      lcgState     = lcgNext(lcgState);
      OpcodeCondIn = {opcode, code};
      Flags        = lcgState[27:24];   // upper lcg bits
   endtask

   initial begin
      OpcodeCondIn = 8'h00;
      Flags        = '0;
      lcgState     = 32'd93;
      timeouts     = 0;
      failures     = 0;

      for (int i = 0; i < ResetTimeout && nReset !== 1'b1; i++) begin
         @(negedge Clock);
      end
      if (nReset !== 1'b1) begin
         timeouts++;
         $display("timeout: reset never released");
      end

      // every opcode up to LLI once
      for (int op = 0; op <= int'(cpuControlPkg::LLI); op++) begin
         runInstruction(5'(op), 3'd0);
      end

      // carry output after adds and compares
      repeat (8) begin
         runInstruction(cpuControlPkg::ADD, 3'd0);
         runInstruction(cpuControlPkg::CMP, 3'd0);
      end

      // each branch code behind a compare with random flags
      repeat (4) begin
         for (int code = 0; code < 8; code++) begin
            runInstruction(cpuControlPkg::CMP, 3'd0);
            runInstruction(cpuControlPkg::BRANCH, 3'(code));
         end
      end

      repeat (3) begin
         runInstruction(cpuControlPkg::LDW, 3'd0);
         runInstruction(cpuControlPkg::STW, 3'd0);
         runInstruction(5'(lcgState % 32'd22), 3'd0);   // random alu opcode
      end

      runInstruction(cpuControlPkg::ADD, 3'd0);
      runInstruction(cpuControlPkg::ADD, 3'd0);
      repeat (7) @(negedge Clock);   // carry of the last add reaches CFlag

      failures = controlUnit_i.controlUnitAssertions_i.failCount;
      $display("assertion failures: %0d  timeouts: %0d", failures, timeouts);
      if (failures == 0 && timeouts == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
verilog/cpuControlPkg.sv
verilog/sequencer.sv
verilog/branchCondition.sv
verilog/controlDecoder.sv
verilog/controlUnit.sv
test/clockGen.sv
test/controlUnitAssertions.sv
test/controlUnitTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = controlUnitTb
FLIST    = flist.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000
SOURCES  = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
